/* source/noc_pkg.sv */
`default_nettype none

package noc_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////
  localparam int noc_flit_data_width = 40;
  localparam int noc_header_width    = 64;
  localparam int noc_header_flits    =
    (noc_header_width + noc_flit_data_width - 1) / noc_flit_data_width;

  typedef enum logic [3:0] {
    noc_read_request   = 4'b0001,
    noc_write_request  = 4'b0010,
    noc_read_response  = 4'b1001, // Bit 3 marks a response
    noc_write_response = 4'b1010
  } noc_packet_type_t;

  typedef struct packed {
    noc_packet_type_t packet_type;
    logic [3:0]       destination_id;
    logic [3:0]       source_id;
    logic [3:0]       tag;
  } noc_common_fields_t;

  typedef struct packed {
    logic [1:0]  burst_type;
    logic [2:0]  burst_size;
    logic [7:0]  burst_length;
    logic [31:0] address;
    logic [2:0]  reserved;
  } noc_request_fields_t;

  typedef struct packed {
    logic [1:0]  status;
    logic [7:0]  burst_length; // Not aligned with the request view
    logic [37:0] reserved;
  } noc_response_fields_t;

  // Decoded by common.packet_type
  typedef union packed {
    noc_request_fields_t  request;
    noc_response_fields_t response;
  } noc_header_fields_u;

  typedef struct packed {
    noc_common_fields_t common;
    noc_header_fields_u fields;
  } noc_header_t;

  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  byte_enable;
  } noc_payload_t;

  typedef logic [noc_flit_data_width-1:0] noc_flit_data_t;

  typedef struct packed {
    logic           is_header;
    logic           tail;
    noc_flit_data_t data;
  } noc_flit_t;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////
  function automatic logic has_payload(input noc_packet_type_t packet_type);
    return packet_type inside {noc_write_request, noc_read_response};
  endfunction

  // Low bits go out first and the last flit is zero filled
  function automatic noc_flit_data_t header_flit_data(input noc_header_t header,
                                                      input logic        index);
    logic [noc_header_flits*noc_flit_data_width-1:0] padded;
    padded = {{(noc_header_flits*noc_flit_data_width-noc_header_width){1'b0}}, header};
    return padded[index*noc_flit_data_width+:noc_flit_data_width];
  endfunction

  function automatic noc_flit_data_t payload_to_flit_data(input noc_payload_t payload);
    return {{(noc_flit_data_width-$bits(noc_payload_t)){1'b0}}, payload};
  endfunction

  function automatic noc_payload_t flit_data_to_payload(input noc_flit_data_t data);
    return noc_payload_t'(data[$bits(noc_payload_t)-1:0]);
  endfunction

endpackage

`default_nettype wire

/* source/noc_flit_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface noc_flit_if;
  import noc_pkg::*;

  logic      valid;
  logic      ready;
  noc_flit_t flit;

  modport initiator (
    output valid,
    input  ready,
    output flit
  );

  modport target (
    input  valid,
    output ready,
    input  flit
  );

endinterface

`default_nettype wire

/* source/noc_packet_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface noc_packet_if;
  import noc_pkg::*;

  // Header channel
  logic         header_valid;
  logic         header_ready;
  noc_header_t  header;

  // Payload channel
  logic         payload_valid;
  logic         payload_ready;
  logic         payload_last;
  noc_payload_t payload;

  modport initiator (
    output header_valid,
    input  header_ready,
    output header,
    output payload_valid,
    input  payload_ready,
    output payload_last,
    output payload
  );

  modport target (
    input  header_valid,
    output header_ready,
    input  header,
    input  payload_valid,
    output payload_ready,
    input  payload_last,
    input  payload
  );

endinterface

`default_nettype wire

/* source/noc_packet_packer.sv */
`timescale 1ns/1ps
`default_nettype none

module noc_packet_packer (
  input  logic          clk,
  input  logic          rst_n,
  noc_packet_if.target  packet_in,
  noc_flit_if.initiator flit_out
);
  import noc_pkg::*;

  logic      header_flit_count;
  logic      header_flit_last;
  logic      header_accept;
  logic      header_tail;
  noc_flit_t flit;

  //////////////////////////////////////////////////
  // Header flits
  //////////////////////////////////////////////////
  assign header_flit_last = (header_flit_count == 1'(noc_header_flits - 1));
  assign header_accept    = packet_in.header_valid && flit_out.ready;

  // Packet ends on its header when no payload follows
  assign header_tail =
    header_flit_last && !has_payload(packet_in.header.common.packet_type);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      header_flit_count <= 1'b0;
    end else if (header_accept) begin
      if (header_flit_last) begin
        header_flit_count <= 1'b0;
      end else begin
        header_flit_count <= header_flit_count + 1'b1;
      end
    end
  end

  // Header is taken only together with its final flit
  assign packet_in.header_ready = header_accept && header_flit_last;

  //////////////////////////////////////////////////
  // Payload flits
  //////////////////////////////////////////////////
  assign packet_in.payload_ready = flit_out.ready && !packet_in.header_valid;

  //////////////////////////////////////////////////
  // Flit mux
  //////////////////////////////////////////////////
  always_comb begin
    flit = '0;
    if (packet_in.header_valid) begin
      flit.is_header = 1'b1;
      flit.tail      = header_tail;
      flit.data      = header_flit_data(packet_in.header, header_flit_count);
    end else begin
      flit.is_header = 1'b0;
      flit.tail      = packet_in.payload_last;
      flit.data      = payload_to_flit_data(packet_in.payload);
    end
  end

  assign flit_out.valid = packet_in.header_valid || packet_in.payload_valid;
  assign flit_out.flit  = flit;

endmodule

`default_nettype wire

/* source/noc_flit_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module noc_flit_fifo #(
  parameter int fifo_depth = 4
) (
  input  logic          clk,
  input  logic          rst_n,
  noc_flit_if.target    flit_in,
  noc_flit_if.initiator flit_out
);
  import noc_pkg::*;

  localparam int ptr_width   = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
  localparam int count_width = $clog2(fifo_depth + 1);

  noc_flit_t              mem [fifo_depth];
  logic [ptr_width-1:0]   wr_ptr;
  logic [ptr_width-1:0]   rd_ptr;
  logic [count_width-1:0] count;
  logic [count_width-1:0] count_next;
  logic                   in_ready;
  logic                   push;
  logic                   pop;

  // Wraps for any depth, not only powers of two
  function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
    if (ptr == ptr_width'(fifo_depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign push = flit_in.valid && in_ready;
  assign pop  = flit_out.valid && flit_out.ready;

  always_comb begin
    count_next = count;
    if (push && !pop) begin
      count_next = count + 1'b1;
    end else if (pop && !push) begin
      count_next = count - 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      in_ready <= 1'b0; // Rises one cycle after reset release
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      count    <= count_next;
      in_ready <= (count_next != count_width'(fifo_depth));
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= flit_in.flit;
    end
  end

  assign flit_in.ready  = in_ready;
  assign flit_out.valid = (count != '0);
  assign flit_out.flit  = mem[rd_ptr]; // Head entry, valid the cycle after its write

endmodule

`default_nettype wire

/* source/noc_packet_unpacker.sv */
`timescale 1ns/1ps
`default_nettype none

module noc_packet_unpacker (
  input  logic             clk,
  input  logic             rst_n,
  noc_flit_if.target       flit_in,
  noc_packet_if.initiator  packet_out
);
  import noc_pkg::*;

  noc_flit_t      flit;
  logic           header_flit_valid;
  logic           header_flit_ready;
  logic           payload_flit_valid;
  logic           payload_flit_ready;
  logic           header_flit_count;
  logic           header_flit_last;
  logic           header_accept;
  noc_flit_data_t header_buffer;
  logic [noc_header_flits*noc_flit_data_width-1:0] header_data;

  //////////////////////////////////////////////////
  // Flit steering
  //////////////////////////////////////////////////
  assign flit               = flit_in.flit;
  assign header_flit_valid  = flit_in.valid && flit.is_header;
  assign payload_flit_valid = flit_in.valid && !flit.is_header;
  assign flit_in.ready      = flit.is_header ? header_flit_ready : payload_flit_ready;

  //////////////////////////////////////////////////
  // Header assembly
  //////////////////////////////////////////////////
  assign header_flit_last  = (header_flit_count == 1'(noc_header_flits - 1));
  assign header_flit_ready = header_flit_last ? packet_out.header_ready : 1'b1;
  assign header_accept     = header_flit_valid && header_flit_ready;

  assign header_data              = {flit.data, header_buffer}; // Buffered flit is the low half
  assign packet_out.header        = noc_header_t'(header_data[noc_header_width-1:0]);
  assign packet_out.header_valid  = header_flit_valid && header_flit_last;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      header_flit_count <= 1'b0;
    end else if (header_accept) begin
      if (header_flit_last) begin
        header_flit_count <= 1'b0;
      end else begin
        header_flit_count <= header_flit_count + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (header_accept) begin
      if (header_flit_last) begin
        header_buffer <= '0;
      end else begin
        header_buffer <= flit.data;
      end
    end
  end

  //////////////////////////////////////////////////
  // Payload
  //////////////////////////////////////////////////
  assign payload_flit_ready       = packet_out.payload_ready;
  assign packet_out.payload_valid = payload_flit_valid;
  assign packet_out.payload_last  = flit.tail;
  assign packet_out.payload       = flit_data_to_payload(flit.data);

endmodule

`default_nettype wire

/* source/noc_link_top.sv */
`timescale 1ns/1ps
`default_nettype none

module noc_link_top #(
  parameter int fifo_depth = 4
) (
  input  logic                 clk,
  input  logic                 rst_n,
  // Local source side
  input  logic                 in_header_valid,
  output logic                 in_header_ready,
  input  noc_pkg::noc_header_t in_header,
  input  logic                 in_payload_valid,
  output logic                 in_payload_ready,
  input  logic                 in_payload_last,
  input  noc_pkg::noc_payload_t in_payload,
  // Local sink side
  output logic                 out_header_valid,
  input  logic                 out_header_ready,
  output noc_pkg::noc_header_t out_header,
  output logic                 out_payload_valid,
  input  logic                 out_payload_ready,
  output logic                 out_payload_last,
  output noc_pkg::noc_payload_t out_payload
);

  noc_packet_if packet_in_if ();
  noc_packet_if packet_out_if ();
  noc_flit_if   link_in ();
  noc_flit_if   link_out ();

  //////////////////////////////////////////////////
  // Port mapping
  //////////////////////////////////////////////////
  assign packet_in_if.header_valid  = in_header_valid;
  assign in_header_ready            = packet_in_if.header_ready;
  assign packet_in_if.header        = in_header;
  assign packet_in_if.payload_valid = in_payload_valid;
  assign in_payload_ready           = packet_in_if.payload_ready;
  assign packet_in_if.payload_last  = in_payload_last;
  assign packet_in_if.payload       = in_payload;

  assign out_header_valid            = packet_out_if.header_valid;
  assign packet_out_if.header_ready  = out_header_ready;
  assign out_header                  = packet_out_if.header;
  assign out_payload_valid           = packet_out_if.payload_valid;
  assign packet_out_if.payload_ready = out_payload_ready;
  assign out_payload_last            = packet_out_if.payload_last;
  assign out_payload                 = packet_out_if.payload;

  //////////////////////////////////////////////////
  // Packer -> FIFO -> unpacker
  //////////////////////////////////////////////////
  noc_packet_packer packer_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .packet_in (packet_in_if.target),
    .flit_out  (link_in.initiator)
  );

  noc_flit_fifo #(
    .fifo_depth (fifo_depth)
  ) fifo_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .flit_in  (link_in.target),
    .flit_out (link_out.initiator)
  );

  noc_packet_unpacker unpacker_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .flit_in    (link_out.target),
    .packet_out (packet_out_if.initiator)
  );

endmodule

`default_nettype wire

/* test/noc_link_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module noc_link_checker (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  in_header_valid,
  input logic                  in_header_ready,
  input logic                  in_payload_valid,
  input logic                  in_payload_ready,
  input logic                  out_header_valid,
  input logic                  out_header_ready,
  input noc_pkg::noc_header_t  out_header,
  input logic                  out_payload_valid,
  input logic                  out_payload_ready,
  input logic                  out_payload_last,
  input noc_pkg::noc_payload_t out_payload
);
  import noc_pkg::*;

  noc_header_t  expected_headers [$];
  noc_payload_t expected_words [$];
  int           expected_counts [$];
  string        expected_names [$];
  string        current_name;
  int           words_left;          // Zero between packets
  int           packet_errors;
  int           packets_done;
  int           packets_passed;
  int           error_count;
  int           backpressure_cycles;
  logic         reset_done = 1'b0;   // Set after the first cycle out of reset

  task automatic expect_header(input string name, input noc_header_t header, input int count);
    expected_names.push_back(name);
    expected_headers.push_back(header);
    expected_counts.push_back(count);
  endtask

  task automatic expect_payload(input noc_payload_t word);
    expected_words.push_back(word);
  endtask

  task automatic count_error();
    error_count++;
    packet_errors++;
  endtask

  task automatic close_packet();
    packets_done++;
    if (packet_errors == 0) begin
      packets_passed++;
      $display("%s: ok", current_name);
    end else begin
      $display("%s: failed with %0d errors", current_name, packet_errors);
    end
  endtask

  task automatic drop_missing_words();
    noc_payload_t skipped;
    repeat (words_left) begin
      skipped = expected_words.pop_front();
    end
    words_left = 0;
  endtask

  //////////////////////////////////////////////////
  // Header and payload comparison
  //////////////////////////////////////////////////
  task automatic take_header();
    noc_header_t expected;
    if (words_left != 0) begin
      $display("%s: next header came with %0d payload words missing", current_name, words_left);
      count_error();
      drop_missing_words();
      close_packet();
    end
    if (expected_headers.size() == 0) begin
      $display("Extra header %h arrived after all expected packets", out_header);
      error_count++;
    end else begin
      current_name  = expected_names.pop_front();
      expected      = expected_headers.pop_front();
      words_left    = expected_counts.pop_front();
      packet_errors = 0;
      if (out_header !== expected) begin
        $display("MISMATCH %s header expected %h actual %h", current_name, expected, out_header);
        count_error();
      end
      if (words_left == 0) begin
        close_packet();
      end
    end
  endtask

  task automatic take_payload();
    noc_payload_t expected;
    if (words_left == 0) begin
      $display("Extra payload word %h arrived outside any packet", out_payload);
      error_count++;
    end else begin
      expected = expected_words.pop_front();
      words_left--;
      if (out_payload !== expected) begin
        $display("MISMATCH %s payload expected %h actual %h", current_name, expected, out_payload);
        count_error();
      end
      if (words_left == 0 && out_payload_last !== 1'b1) begin
        $display("%s: final payload word came without the last marker", current_name);
        count_error();
      end else if (words_left != 0 && out_payload_last === 1'b1) begin
        $display("%s: last marker came with %0d payload words missing", current_name, words_left);
        count_error();
        drop_missing_words();
      end
      if (words_left == 0) begin
        close_packet();
      end
    end
  endtask

  task automatic check_backpressure();
    if (backpressure_cycles == 0) begin
      $display("Input side never stalled while the sink held ready low");
      error_count++;
    end
  endtask

  // Handshakes sampled mid-cycle complete on the next rising edge
  always @(negedge clk) begin
    if (rst_n !== 1'b1 || !reset_done) begin
      if ({out_header_valid, out_payload_valid, in_header_ready, in_payload_ready} !== 4'b0) begin
        $display("A valid or ready output was high during or just after reset");
        error_count++;
      end
      reset_done = (rst_n === 1'b1);
    end else begin
      // Payload stall with no header pending means the FIFO is full
      if (!out_header_ready && !out_payload_ready &&
          in_payload_valid && !in_payload_ready && !in_header_valid) begin
        backpressure_cycles++;
      end
      if (out_header_valid && out_header_ready) begin
        take_header();
      end
      if (out_payload_valid && out_payload_ready) begin
        take_payload();
      end
    end
  end

endmodule

`default_nettype wire

/* test/noc_link_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module noc_link_tb;
  import noc_pkg::*;

  localparam int fifo_depth   = 4;
  localparam int num_tests    = 8;
  localparam int reset_cycles = 5;

  typedef struct packed {
    noc_packet_type_t packet_type;
    logic [3:0]       destination_id;
    logic [3:0]       source_id;
    logic [3:0]       tag;
    logic [31:0]      address_or_status;
    logic [7:0]       burst_length;
    logic [7:0]       stall_cycles; // Sink ready low before this packet
    logic [7:0]       ready_mask;   // Sink ready, one bit per cycle
  } test_entry_t;

  //////////////////////////////////////////////////
  // Stimulus table
  //////////////////////////////////////////////////
  string test_names [num_tests] = '{
    "read_request", "write_burst_8", "read_response", "write_response",
    "write_long_stall", "mixed_read_request", "mixed_write", "mixed_read_response"
  };
  test_entry_t tests [num_tests] = '{
    '{noc_read_request,   4'd1, 4'd2, 4'd3, 32'h1000_0040, 8'd4, 8'd0,  8'hff},
    '{noc_write_request,  4'd2, 4'd1, 4'd4, 32'h2000_0100, 8'd8, 8'd0,  8'hff},
    '{noc_read_response,  4'd1, 4'd2, 4'd3, 32'h0000_0001, 8'd3, 8'd0,  8'hb6},
    '{noc_write_response, 4'd1, 4'd2, 4'd4, 32'h0000_0002, 8'd1, 8'd0,  8'hff},
    '{noc_write_request,  4'd5, 4'd6, 4'd7, 32'h3000_0000, 8'd8, 8'd40, 8'hff},
    '{noc_read_request,   4'd7, 4'd3, 4'd1, 32'hdead_beec, 8'd2, 8'd0,  8'hff},
    '{noc_write_request,  4'd3, 4'd7, 4'd2, 32'h0000_0ff0, 8'd2, 8'd0,  8'h55},
    '{noc_read_response,  4'd6, 4'd5, 4'd9, 32'h0000_0003, 8'd5, 8'd0,  8'he7}
  };

  logic         clk;
  logic         rst_n;
  logic         in_header_valid;
  logic         in_header_ready;
  noc_header_t  in_header;
  logic         in_payload_valid;
  logic         in_payload_ready;
  logic         in_payload_last;
  noc_payload_t in_payload;
  logic         out_header_valid;
  logic         out_header_ready;
  noc_header_t  out_header;
  logic         out_payload_valid;
  logic         out_payload_ready;
  logic         out_payload_last;
  noc_payload_t out_payload;
  logic [31:0]  rng_state = 32'd85;

  noc_link_top #(.fifo_depth(fifo_depth)) noc_link_top_i (.*);
  noc_link_checker checker_i (.*);

  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Write requests and read responses carry data words
  function automatic bit expects_payload(input noc_packet_type_t packet_type);
    return (packet_type == noc_write_request) || (packet_type == noc_read_response);
  endfunction

  function automatic noc_header_t build_header(input test_entry_t entry);
    noc_header_t header;
    header = '0;
    header.common = '{entry.packet_type, entry.destination_id, entry.source_id, entry.tag};
    if (entry.packet_type == noc_read_response || entry.packet_type == noc_write_response) begin
      header.fields.response.status       = entry.address_or_status[1:0];
      header.fields.response.burst_length = entry.burst_length;
    end else begin
      header.fields.request.burst_type   = 2'b01; // Incrementing
      header.fields.request.burst_size   = 3'b010;
      header.fields.request.burst_length = entry.burst_length;
      header.fields.request.address      = entry.address_or_status;
    end
    return header;
  endfunction

  task automatic send_packet(input int index);
    noc_header_t  header;
    noc_payload_t words [8];
    int           count;
    int           k;
    header = build_header(tests[index]);
    count  = expects_payload(tests[index].packet_type) ? int'(tests[index].burst_length) : 0;
    checker_i.expect_header(test_names[index], header, count);
    for (k = 0; k < count; k++) begin
      rng_state            = xorshift32(rng_state);
      words[k].data        = rng_state;
      rng_state            = xorshift32(rng_state);
      words[k].byte_enable = rng_state[3:0];
      checker_i.expect_payload(words[k]);
    end
    in_header       = header;
    in_header_valid = 1'b1;
    do begin
      @(negedge clk);
    end while (!in_header_ready);
    @(posedge clk);
    #2;
    in_header_valid = 1'b0;
    for (k = 0; k < count; k++) begin
      in_payload       = words[k];
      in_payload_last  = (k == count - 1);
      in_payload_valid = 1'b1;
      do begin
        @(negedge clk);
      end while (!in_payload_ready);
      @(posedge clk);
      #2;
    end
    in_payload_valid = 1'b0;
    in_payload_last  = 1'b0;
  endtask

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Source, sink and watchdog
  //////////////////////////////////////////////////
  initial begin
    rst_n            = 1'b0;
    in_header_valid  = 1'b0;
    in_header        = '0;
    in_payload_valid = 1'b0;
    in_payload_last  = 1'b0;
    in_payload       = '0;
    repeat (reset_cycles) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(posedge clk);
    #2;
    for (int i = 0; i < num_tests; i++) begin
      send_packet(i); // Back to back, no idle cycles
    end
    wait (checker_i.packets_done == num_tests);
    repeat (10) @(posedge clk); // Room for stray flits
    checker_i.check_backpressure();
    $display("Packets %0d, passed %0d, failed %0d, errors %0d", num_tests,
             checker_i.packets_passed, num_tests - checker_i.packets_passed,
             checker_i.error_count);
    if (checker_i.error_count == 0 && checker_i.packets_passed == num_tests) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    int phase;
    phase             = 0;
    out_header_ready  = 1'b0;
    out_payload_ready = 1'b0;
    wait (rst_n === 1'b1);
    @(posedge clk);
    #2;
    for (int i = 0; i < num_tests; i++) begin
      out_header_ready  = 1'b0;
      out_payload_ready = 1'b0;
      repeat (tests[i].stall_cycles) begin
        @(posedge clk);
        #2;
      end
      while (checker_i.packets_done <= i) begin
        out_header_ready  = tests[i].ready_mask[phase % 8];
        out_payload_ready = tests[i].ready_mask[phase % 8];
        phase++;
        @(posedge clk);
        #2;
      end
    end
    out_header_ready  = 1'b1;
    out_payload_ready = 1'b1;
  end

  initial begin
    int limit;
    limit = reset_cycles;
    for (int i = 0; i < num_tests; i++) begin
      limit += (int'(tests[i].burst_length) + 4) * 20;
    end
    repeat (limit) @(posedge clk);
    $display("Timeout after %0d cycles with %0d of %0d packets received",
             limit, checker_i.packets_done, num_tests);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
source/noc_pkg.sv
source/noc_flit_if.sv
source/noc_packet_if.sv
source/noc_packet_packer.sv
source/noc_flit_fifo.sv
source/noc_packet_unpacker.sv
source/noc_link_top.sv
test/noc_link_checker.sv
test/noc_link_tb.sv
